/* design/mod_add_sub.sv */
// Combinational modular adder/subtractor for operands already below the modulus
`timescale 1ns/1ps
`default_nettype none

module mod_add_sub (
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0] sum_a,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0] sum_b,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0] modulo,
  input wire                                  subtract,
  output logic [scalar_mod_pkg::DATA_SIZE-1:0] result
);

  logic [scalar_mod_pkg::DATA_SIZE:0] mod_ext;
  logic [scalar_mod_pkg::DATA_SIZE:0] sum;
  logic [scalar_mod_pkg::DATA_SIZE:0] sum_wrap;
  logic [scalar_mod_pkg::DATA_SIZE:0] diff;
  logic [scalar_mod_pkg::DATA_SIZE:0] diff_fix;

  assign mod_ext = {1'b0, modulo};

  // Sum with carry bit, wrap once
  assign sum      = {1'b0, sum_a} + {1'b0, sum_b};
  assign sum_wrap = sum - mod_ext;

  // Difference, top bit is the borrow
  assign diff     = {1'b0, sum_a} - {1'b0, sum_b};
  assign diff_fix = diff + mod_ext;

  always_comb begin
    if (subtract) begin
      // Borrow means negative, add modulus back
      result = diff[scalar_mod_pkg::DATA_SIZE] ? diff_fix[scalar_mod_pkg::DATA_SIZE-1:0]
                                               : diff[scalar_mod_pkg::DATA_SIZE-1:0];
    end else begin
      result = (sum >= mod_ext) ? sum_wrap[scalar_mod_pkg::DATA_SIZE-1:0]
                                : sum[scalar_mod_pkg::DATA_SIZE-1:0];
    end
  end

endmodule

`default_nettype wire

/* design/mod_multiplier.sv */
// Modular multiplier: interleaved shift-add, MSB first, with conditional subtraction
`timescale 1ns/1ps
`default_nettype none

module mod_multiplier (
  input wire     CLK,
  input wire     RST,
  mod_op_if.unit bus
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Remaining steps, zero when idle
  logic [scalar_mod_pkg::CNT_WIDTH-1:0] count;

  // Multiplier bits, top bit is the current one
  logic [scalar_mod_pkg::DATA_SIZE-1:0] a_shift;

  // One spare bit so doubling never overflows
  logic [scalar_mod_pkg::DATA_SIZE:0]   acc;

  logic [scalar_mod_pkg::DATA_SIZE:0]   mod_ext;
  logic [scalar_mod_pkg::DATA_SIZE:0]   dbl;
  logic [scalar_mod_pkg::DATA_SIZE:0]   dbl_red;
  logic [scalar_mod_pkg::DATA_SIZE:0]   sum;
  logic [scalar_mod_pkg::DATA_SIZE:0]   acc_next;

  //////////////////////////////
  // Step datapath
  //////////////////////////////

  assign mod_ext = {1'b0, bus.modulo};

  always_comb begin
    // Double, then bring back below modulus
    dbl     = acc << 1;
    dbl_red = (dbl >= mod_ext) ? (dbl - mod_ext) : dbl;

    // Add multiplicand when current bit set
    sum = dbl_red + {1'b0, bus.operand_b};
    if (a_shift[scalar_mod_pkg::DATA_SIZE-1]) begin
      acc_next = (sum >= mod_ext) ? (sum - mod_ext) : sum;
    end else begin
      acc_next = dbl_red;
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count    <= '0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= 1'b0;
      if (count == '0) begin
        // Ignore start while busy
        if (bus.start) begin
          count <= scalar_mod_pkg::STEP_COUNT;
        end
      end else begin
        count <= count - 1'b1;
        if (count == 1'b1) begin
          bus.done <= 1'b1;
        end
      end
    end
  end

  // Accumulator and multiplier shift register
  always_ff @(posedge CLK) begin
    if (count == '0) begin
      if (bus.start) begin
        acc     <= '0;
        a_shift <= bus.operand_a;
      end
    end else begin
      acc     <= acc_next;
      a_shift <= a_shift << 1;
    end
  end

  // Accumulator stays below modulus, top bit is always clear
  assign bus.result = acc[scalar_mod_pkg::DATA_SIZE-1:0];

endmodule

`default_nettype wire

/* design/mod_op_if.sv */
// Start/done request bus between the controller and a sequential modular datapath unit
`timescale 1ns/1ps
`default_nettype none

interface mod_op_if;

  // Request side
  logic                               start;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] operand_a;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] operand_b;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] modulo;

  // Completion side, result valid with done
  logic                               done;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] result;

  // Controller view
  modport requester (
    output start,
    output operand_a,
    output operand_b,
    output modulo,
    input  done,
    input  result
  );

  // Datapath view
  modport unit (
    input  start,
    input  operand_a,
    input  operand_b,
    input  modulo,
    output done,
    output result
  );

endinterface

`default_nettype wire

/* design/mod_reducer.sv */
// Modular reducer: restoring shift-subtract division keeping the remainder
`timescale 1ns/1ps
`default_nettype none

module mod_reducer (
  input wire     CLK,
  input wire     RST,
  mod_op_if.unit bus
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Remaining steps, zero when idle
  logic [scalar_mod_pkg::CNT_WIDTH-1:0] count;

  // Partial remainder and dividend bits still to bring in
  logic [scalar_mod_pkg::DATA_SIZE-1:0] rem;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] dividend;

  logic [scalar_mod_pkg::DATA_SIZE:0]   mod_ext;
  logic [scalar_mod_pkg::DATA_SIZE:0]   trial;
  logic [scalar_mod_pkg::DATA_SIZE:0]   trial_sub;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] rem_next;

  //////////////////////////////
  // Step datapath
  //////////////////////////////

  // Shift remainder left, pull in next dividend bit
  assign mod_ext   = {1'b0, bus.modulo};
  assign trial     = {rem, dividend[scalar_mod_pkg::DATA_SIZE-1]};
  assign trial_sub = trial - mod_ext;

  // Restore unless trial is at or above modulus
  assign rem_next = (trial >= mod_ext) ? trial_sub[scalar_mod_pkg::DATA_SIZE-1:0]
                                       : trial[scalar_mod_pkg::DATA_SIZE-1:0];

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count    <= '0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= 1'b0;
      if (count == '0) begin
        // Accept only when idle
        if (bus.start) begin
          count <= scalar_mod_pkg::STEP_COUNT;
        end
      end else begin
        count <= count - 1'b1;
        // Last step, remainder lands with done
        if (count == 1'b1) begin
          bus.done <= 1'b1;
        end
      end
    end
  end

  // Datapath registers
  always_ff @(posedge CLK) begin
    if (count == '0) begin
      if (bus.start) begin
        rem      <= '0;
        dividend <= bus.operand_a;
      end
    end else begin
      rem      <= rem_next;
      dividend <= dividend << 1;
    end
  end

  assign bus.result = rem;

endmodule

`default_nettype wire

/* design/scalar_mod_ctrl.sv */
// Scalar modular unit controller: sequences reduction, add/sub, multiply and divide
`timescale 1ns/1ps
`default_nettype none

module scalar_mod_ctrl (
  input wire                                   CLK,
  input wire                                   RST,
  input wire                                   START,
  input wire scalar_mod_pkg::op_code_t         OPCODE,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  MODULO_IN,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  DATA_A_IN,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  DATA_B_IN,
  output logic                                 READY,
  output logic [scalar_mod_pkg::DATA_SIZE-1:0] DATA_OUT,
  mod_op_if.requester                          reduce_bus,
  mod_op_if.requester                          mult_bus,
  output logic [scalar_mod_pkg::DATA_SIZE-1:0] sum_a,
  output logic [scalar_mod_pkg::DATA_SIZE-1:0] sum_b,
  output logic                                 subtract,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  sum_result
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // FSM
  scalar_mod_pkg::ctrl_state_t state;

  // Latched request
  scalar_mod_pkg::op_code_t             op_q;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] mod_q;

  // Operands, raw then reduced in place
  logic [scalar_mod_pkg::DATA_SIZE-1:0] a_q;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] b_q;

  // Running product: reduced B for multiply, power of B for divide
  logic [scalar_mod_pkg::DATA_SIZE-1:0] acc;

  // Divide exponent (modulus minus 2) and its scan position
  logic [scalar_mod_pkg::DATA_SIZE-1:0]     exp_q;
  logic [scalar_mod_pkg::BIT_IDX_WIDTH-1:0] bit_idx;

  // Start strobes
  logic reduce_start;
  logic mult_start;

  //////////////////////////////
  // FSM and outputs
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= scalar_mod_pkg::IDLE;
      reduce_start <= 1'b0;
      mult_start   <= 1'b0;
      bit_idx      <= '0;
      READY        <= 1'b0;
      DATA_OUT     <= '0;
    end else begin
      // Strobes last one cycle
      reduce_start <= 1'b0;
      mult_start   <= 1'b0;
      READY        <= 1'b0;
      case (state)
        scalar_mod_pkg::IDLE: begin
          if (START) begin
            reduce_start <= 1'b1;
            state        <= scalar_mod_pkg::REDUCE_A;
          end
        end
        scalar_mod_pkg::REDUCE_A: begin
          if (reduce_bus.done) begin
            reduce_start <= 1'b1;
            state        <= scalar_mod_pkg::REDUCE_B;
          end
        end
        scalar_mod_pkg::REDUCE_B: begin
          if (reduce_bus.done) begin
            case (op_q)
              scalar_mod_pkg::OP_ADD,
              scalar_mod_pkg::OP_SUB: begin
                state <= scalar_mod_pkg::ADD_SUB;
              end
              scalar_mod_pkg::OP_MUL: begin
                mult_start <= 1'b1;
                state      <= scalar_mod_pkg::MULTIPLY;
              end
              default: begin
                // Divide: square-and-multiply from the top exponent bit
                mult_start <= 1'b1;
                bit_idx    <= scalar_mod_pkg::TOP_BIT;
                state      <= scalar_mod_pkg::EXP_SQUARE;
              end
            endcase
          end
        end
        scalar_mod_pkg::ADD_SUB: begin
          DATA_OUT <= sum_result;
          READY    <= 1'b1;
          state    <= scalar_mod_pkg::FINISH;
        end
        scalar_mod_pkg::MULTIPLY: begin
          if (mult_bus.done) begin
            DATA_OUT <= mult_bus.result;
            READY    <= 1'b1;
            state    <= scalar_mod_pkg::FINISH;
          end
        end
        scalar_mod_pkg::EXP_SQUARE: begin
          if (mult_bus.done) begin
            mult_start <= 1'b1;
            if (exp_q[bit_idx]) begin
              state <= scalar_mod_pkg::EXP_MULTIPLY;
            end else if (bit_idx == '0) begin
              // Exponent done, final product with A
              state <= scalar_mod_pkg::MULTIPLY;
            end else begin
              bit_idx <= bit_idx - 1'b1;
            end
          end
        end
        scalar_mod_pkg::EXP_MULTIPLY: begin
          if (mult_bus.done) begin
            mult_start <= 1'b1;
            if (bit_idx == '0) begin
              state <= scalar_mod_pkg::MULTIPLY;
            end else begin
              bit_idx <= bit_idx - 1'b1;
              state   <= scalar_mod_pkg::EXP_SQUARE;
            end
          end
        end
        scalar_mod_pkg::FINISH: begin
          // READY high this cycle
          state <= scalar_mod_pkg::IDLE;
        end
        default: begin
          state <= scalar_mod_pkg::IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Operand registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      scalar_mod_pkg::IDLE: begin
        if (START) begin
          op_q  <= OPCODE;
          mod_q <= MODULO_IN;
          a_q   <= DATA_A_IN;
          b_q   <= DATA_B_IN;
          exp_q <= MODULO_IN - 2'd2;
        end
      end
      scalar_mod_pkg::REDUCE_A: begin
        if (reduce_bus.done) begin
          a_q <= reduce_bus.result;
        end
      end
      scalar_mod_pkg::REDUCE_B: begin
        if (reduce_bus.done) begin
          b_q <= reduce_bus.result;
          // Divide starts exponentiation from 1
          acc <= (op_q == scalar_mod_pkg::OP_DIV) ? 1'b1 : reduce_bus.result;
        end
      end
      scalar_mod_pkg::EXP_SQUARE,
      scalar_mod_pkg::EXP_MULTIPLY: begin
        if (mult_bus.done) begin
          acc <= mult_bus.result;
        end
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // Datapath requests
  //////////////////////////////

  // Reducer sees A first, then B
  assign reduce_bus.start     = reduce_start;
  assign reduce_bus.operand_a = (state == scalar_mod_pkg::REDUCE_A) ? a_q : b_q;
  assign reduce_bus.operand_b = '0;
  assign reduce_bus.modulo    = mod_q;

  // Square: acc*acc, step multiply: acc*B, final: A*acc
  assign mult_bus.start     = mult_start;
  assign mult_bus.operand_a = (state == scalar_mod_pkg::MULTIPLY) ? a_q : acc;
  assign mult_bus.operand_b = (state == scalar_mod_pkg::EXP_MULTIPLY) ? b_q : acc;
  assign mult_bus.modulo    = mod_q;

  // Add/sub on reduced operands
  assign sum_a    = a_q;
  assign sum_b    = b_q;
  assign subtract = (op_q == scalar_mod_pkg::OP_SUB);

endmodule

`default_nettype wire

/* design/scalar_mod_pkg.sv */
// Scalar modular arithmetic unit package: data width, opcodes and controller states
`default_nettype none

package scalar_mod_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operand, modulus and result width
  localparam int DATA_SIZE = 16;

  // Step counter of the bit-serial units
  localparam int CNT_WIDTH = $clog2(DATA_SIZE + 1);
  localparam logic [CNT_WIDTH-1:0] STEP_COUNT = CNT_WIDTH'(DATA_SIZE);

  // Exponent bit index for divide
  localparam int BIT_IDX_WIDTH = $clog2(DATA_SIZE);
  localparam logic [BIT_IDX_WIDTH-1:0] TOP_BIT = BIT_IDX_WIDTH'(DATA_SIZE - 1);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_DIV = 2'd3
  } op_code_t;

  // Controller FSM encoding
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    REDUCE_A     = 3'd1,
    REDUCE_B     = 3'd2,
    ADD_SUB      = 3'd3,
    MULTIPLY     = 3'd4,
    EXP_SQUARE   = 3'd5,
    EXP_MULTIPLY = 3'd6,
    FINISH       = 3'd7
  } ctrl_state_t;

endpackage

`default_nettype wire

/* design/scalar_mod_unit.sv */
// Scalar modular arithmetic unit top: controller with reducer, multiplier and add/sub
`timescale 1ns/1ps
`default_nettype none

module scalar_mod_unit (
  input wire                                   CLK,
  input wire                                   RST,
  input wire                                   START,
  input wire scalar_mod_pkg::op_code_t         OPCODE,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  MODULO_IN,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  DATA_A_IN,
  input wire  [scalar_mod_pkg::DATA_SIZE-1:0]  DATA_B_IN,
  output logic                                 READY,
  output logic [scalar_mod_pkg::DATA_SIZE-1:0] DATA_OUT
);

  //////////////////////////////
  // Buses and wires
  //////////////////////////////

  mod_op_if reduce_bus ();
  mod_op_if mult_bus ();

  // Add/sub path
  logic [scalar_mod_pkg::DATA_SIZE-1:0] sum_a;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] sum_b;
  logic                                 subtract;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] sum_result;

  //////////////////////////////
  // Instances
  //////////////////////////////

  scalar_mod_ctrl u_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .OPCODE     (OPCODE),
    .MODULO_IN  (MODULO_IN),
    .DATA_A_IN  (DATA_A_IN),
    .DATA_B_IN  (DATA_B_IN),
    .READY      (READY),
    .DATA_OUT   (DATA_OUT),
    .reduce_bus (reduce_bus.requester),
    .mult_bus   (mult_bus.requester),
    .sum_a      (sum_a),
    .sum_b      (sum_b),
    .subtract   (subtract),
    .sum_result (sum_result)
  );

  mod_reducer u_reducer (
    .CLK (CLK),
    .RST (RST),
    .bus (reduce_bus.unit)
  );

  mod_multiplier u_multiplier (
    .CLK (CLK),
    .RST (RST),
    .bus (mult_bus.unit)
  );

  // Latched modulus taken from the reducer bus
  mod_add_sub u_add_sub (
    .sum_a    (sum_a),
    .sum_b    (sum_b),
    .modulo   (reduce_bus.modulo),
    .subtract (subtract),
    .result   (sum_result)
  );

endmodule

`default_nettype wire

/* dv/scalar_mod_unit_assertions.sv */
// Protocol checker for the scalar modular unit ports, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module scalar_mod_unit_assertions (
  input wire                                  CLK,
  input wire                                  RST,
  input wire                                  START,
  input wire [scalar_mod_pkg::DATA_SIZE-1:0]  MODULO_IN,
  input wire                                  READY,
  input wire [scalar_mod_pkg::DATA_SIZE-1:0]  DATA_OUT,
  input wire scalar_mod_pkg::ctrl_state_t     ctrl_state
);

  // Failed assertion count, watched by the testbench
  int error_count = 0;

  // Operation in flight, from accepted START until READY
  logic busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
    end else if (START && (ctrl_state == scalar_mod_pkg::IDLE)) begin
      busy <= 1'b1;
    end else if (READY) begin
      busy <= 1'b0;
    end
  end

  //////////////////////////////
  // Port protocol
  //////////////////////////////

  // READY is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else begin
      $error("READY stayed high for two consecutive cycles");
      error_count++;
    end

  // Outputs cleared while in reset
  reset_outputs_zero: assert property (@(posedge CLK) RST |-> (!READY && (DATA_OUT == '0)))
    else begin
      $error("READY or DATA_OUT not zero during reset");
      error_count++;
    end

  // Result always reduced
  result_below_modulus: assert property (@(posedge CLK) disable iff (RST)
    READY |-> (DATA_OUT < MODULO_IN))
    else begin
      $error("DATA_OUT not below MODULO_IN while READY is high");
      error_count++;
    end

  // No READY without an accepted START
  ready_after_start: assert property (@(posedge CLK) disable iff (RST) $rose(READY) |-> busy)
    else begin
      $error("READY rose without an accepted START");
      error_count++;
    end

endmodule

bind scalar_mod_unit scalar_mod_unit_assertions protocol_checks (
  .CLK        (CLK),
  .RST        (RST),
  .START      (START),
  .MODULO_IN  (MODULO_IN),
  .READY      (READY),
  .DATA_OUT   (DATA_OUT),
  .ctrl_state (u_ctrl.state)
);

`default_nettype wire

/* dv/scalar_mod_unit_tb.sv */
// Testbench for the scalar modular unit: directed, random and handshake checks
`timescale 1ns/1ps
`default_nettype none

module scalar_mod_unit_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                                 CLK;
  logic                                 RST;
  logic                                 START;
  scalar_mod_pkg::op_code_t             OPCODE;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] MODULO_IN;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] DATA_A_IN;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] DATA_B_IN;
  logic                                 READY;
  logic [scalar_mod_pkg::DATA_SIZE-1:0] DATA_OUT;

  // Last captured result, DATA_OUT must hold it between READY pulses
  longint last_out;

  scalar_mod_unit UUT (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .OPCODE    (OPCODE),
    .MODULO_IN (MODULO_IN),
    .DATA_A_IN (DATA_A_IN),
    .DATA_B_IN (DATA_B_IN),
    .READY     (READY),
    .DATA_OUT  (DATA_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Square-and-multiply on plain integers
  function automatic longint pow_mod(input longint base, input longint e, input longint m);
    longint res;
    longint sq;
    longint x;
    res = 1;
    sq  = base % m;
    x   = e;
    while (x > 0) begin
      if (x & 1) begin
        res = (res * sq) % m;
      end
      sq = (sq * sq) % m;
      x  = x >> 1;
    end
    return res;
  endfunction

  function automatic longint model_result(input scalar_mod_pkg::op_code_t op,
                                          input longint m, input longint a, input longint b);
    longint ra;
    longint rb;
    ra = a % m;
    rb = b % m;
    case (op)
      scalar_mod_pkg::OP_ADD: return (ra + rb) % m;
      scalar_mod_pkg::OP_SUB: return (ra - rb + m) % m;
      scalar_mod_pkg::OP_MUL: return (ra * rb) % m;
      // Fermat inverse, prime modulus only
      default: return (ra * pow_mod(rb, m - 2, m)) % m;
    endcase
  endfunction

  function automatic logic [scalar_mod_pkg::DATA_SIZE-1:0] random_modulus();
    return scalar_mod_pkg::DATA_SIZE'(($urandom % 65534) + 2);
  endfunction

  // Full-width random operand
  function automatic logic [scalar_mod_pkg::DATA_SIZE-1:0] random_operand();
    return scalar_mod_pkg::DATA_SIZE'($urandom);
  endfunction

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input longint exp, input longint act);
    fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // Any bound protocol assertion failure ends the run
  always @(negedge CLK) begin
    if (UUT.protocol_checks.error_count != 0) begin
      fail_run("a protocol assertion on the DUT ports failed");
    end
  end

  //////////////////////////////
  // Operation helpers
  //////////////////////////////

  // Called right after a rising edge; START high for one cycle
  task automatic start_op(input scalar_mod_pkg::op_code_t op,
                          input logic [scalar_mod_pkg::DATA_SIZE-1:0] m,
                          input logic [scalar_mod_pkg::DATA_SIZE-1:0] a,
                          input logic [scalar_mod_pkg::DATA_SIZE-1:0] b);
    OPCODE    <= op;
    MODULO_IN <= m;
    DATA_A_IN <= a;
    DATA_B_IN <= b;
    START     <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
  endtask

  // Returns on the edge that samples READY high
  task automatic wait_ready(input string name);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < TIMEOUT_CYCLES)) begin
      @(posedge CLK);
      cycles++;
      if (READY) begin
        seen = 1'b1;
      end else begin
        assert (longint'(DATA_OUT) == last_out)
          else report_mismatch({name, " hold"}, last_out, DATA_OUT);
      end
    end
    if (!seen) begin
      fail_run($sformatf("timeout: no READY for %s after %0d cycles", name, cycles));
    end
  endtask

  task automatic check_result(input string name, input scalar_mod_pkg::op_code_t op,
                              input longint m, input longint a, input longint b);
    longint expected;
    longint back;
    expected = model_result(op, m, a, b);
    // Quotient times B must give back A
    if ((op == scalar_mod_pkg::OP_DIV) && ((b % m) != 0)) begin
      back = (longint'(DATA_OUT) * b) % m;
      assert (back == (a % m))
        else report_mismatch({name, " times B"}, a % m, back);
    end
    assert (longint'(DATA_OUT) == expected)
      else report_mismatch(name, expected, DATA_OUT);
    last_out = DATA_OUT;
  endtask

  task automatic run_op(input string name, input scalar_mod_pkg::op_code_t op,
                        input logic [scalar_mod_pkg::DATA_SIZE-1:0] m,
                        input logic [scalar_mod_pkg::DATA_SIZE-1:0] a,
                        input logic [scalar_mod_pkg::DATA_SIZE-1:0] b);
    start_op(op, m, a, b);
    wait_ready(name);
    check_result(name, op, m, a, b);
  endtask

  // Second START mid-operation with other operands must be dropped
  task automatic busy_start_test(input string name, input scalar_mod_pkg::op_code_t op,
                                 input logic [scalar_mod_pkg::DATA_SIZE-1:0] m,
                                 input logic [scalar_mod_pkg::DATA_SIZE-1:0] a,
                                 input logic [scalar_mod_pkg::DATA_SIZE-1:0] b,
                                 input int delay);
    int i;
    start_op(op, m, a, b);
    repeat (delay) @(posedge CLK);
    DATA_A_IN <= ~a;
    DATA_B_IN <= b + 16'd1;
    START     <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    wait_ready(name);
    check_result(name, op, m, a, b);
    // No second READY may follow
    for (i = 0; i < 60; i++) begin
      @(posedge CLK);
      assert (!READY) else fail_run({"second READY after START while busy in ", name});
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int i;
    logic [scalar_mod_pkg::DATA_SIZE-1:0] primes [4];
    scalar_mod_pkg::op_code_t op;
    logic [scalar_mod_pkg::DATA_SIZE-1:0] m;
    void'($urandom(44089));
    primes    = '{16'd65521, 16'd251, 16'd3, 16'd7};
    RST       = 1'b1;
    START     = 1'b0;
    OPCODE    = scalar_mod_pkg::OP_ADD;
    MODULO_IN = '0;
    DATA_A_IN = '0;
    DATA_B_IN = '0;
    last_out  = 0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);

    // Add and subtract, unreduced operands and wrap below zero
    run_op("add_full", scalar_mod_pkg::OP_ADD, 16'd97, 16'hFFFF, 16'hFFFE);
    run_op("sub_wrap", scalar_mod_pkg::OP_SUB, 16'd97, 16'd200, 16'hFFFF);
    run_op("add_mod2", scalar_mod_pkg::OP_ADD, 16'd2, 16'hFFFF, 16'd1);
    run_op("sub_mod2", scalar_mod_pkg::OP_SUB, 16'd2, 16'd4, 16'd3);
    run_op("add_max", scalar_mod_pkg::OP_ADD, 16'hFFFF, 16'hFFFF, 16'hFFFE);
    run_op("sub_max", scalar_mod_pkg::OP_SUB, 16'hFFFF, 16'd0, 16'hFFFE);
    for (i = 0; i < 8; i++) begin
      op = (i % 2) ? scalar_mod_pkg::OP_SUB : scalar_mod_pkg::OP_ADD;
      run_op($sformatf("addsub_rand_%0d", i), op, random_modulus(),
             random_operand(), random_operand());
    end

    // Multiply
    run_op("mul_max_red", scalar_mod_pkg::OP_MUL, 16'hFFFF, 16'hFFFE, 16'hFFFE);
    run_op("mul_max_raw", scalar_mod_pkg::OP_MUL, 16'hFFFF, 16'hFFFF, 16'hFFFF);
    run_op("mul_mod2", scalar_mod_pkg::OP_MUL, 16'd2, 16'hFFFF, 16'd3);
    for (i = 0; i < 16; i++) begin
      run_op($sformatf("mul_rand_%0d", i), scalar_mod_pkg::OP_MUL, random_modulus(),
             random_operand(), random_operand());
    end

    // Divide, prime moduli only
    run_op("div_zero_b", scalar_mod_pkg::OP_DIV, 16'd65521, 16'd1234, 16'd65521);
    run_op("div_mod3", scalar_mod_pkg::OP_DIV, 16'd3, 16'd2, 16'd2);
    for (i = 0; i < 12; i++) begin
      m = primes[i % 4];
      run_op($sformatf("div_rand_%0d", i), scalar_mod_pkg::OP_DIV, m,
             random_operand(), random_operand());
    end

    // START while busy, early in add and deep in divide
    busy_start_test("busy_add", scalar_mod_pkg::OP_ADD, 16'd1009, 16'd5000, 16'd777, 5);
    busy_start_test("busy_div", scalar_mod_pkg::OP_DIV, 16'd251, 16'd9999, 16'd4321, 100);

    // Back to back, all opcodes mixed
    for (i = 0; i < 16; i++) begin
      op = scalar_mod_pkg::op_code_t'(i % 4);
      m  = (op == scalar_mod_pkg::OP_DIV) ? primes[(i / 4) % 4] : random_modulus();
      run_op($sformatf("b2b_%0d", i), op, m, random_operand(), random_operand());
    end

    repeat (4) @(posedge CLK);
    if (UUT.protocol_checks.error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run("a protocol assertion on the DUT ports failed");
    end
  end

endmodule

`default_nettype wire

/* scalar_mod_unit.f */
design/scalar_mod_pkg.sv
design/mod_op_if.sv
design/mod_reducer.sv
design/mod_multiplier.sv
design/mod_add_sub.sv
design/scalar_mod_ctrl.sv
design/scalar_mod_unit.sv
dv/scalar_mod_unit_assertions.sv
dv/scalar_mod_unit_tb.sv
